// ==== hdl/cache_ctrl.sv ====
`timescale 1ns/1ps

module cache_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  logic                cpu_read,
    input  logic                cpu_write,
    input  logic                hit,
    input  logic                dirty_miss,
    input  logic                clean_miss,
    input  logic                dfp_resp,
    output cache_pkg::sram_op_t sram_op,
    output logic                cpu_resp,
    output logic                dfp_read,
    output logic                dfp_write
);

    typedef enum logic [1:0] {
        idle,
        compare_tag,
        write_back,
        allocate
    } state_t;

    state_t state_q;
    state_t state_d;
    logic   cpu_req;

    assign cpu_req = cpu_read || cpu_write;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d   = state_q;
        sram_op   = cache_pkg::SRAM_NOP;
        cpu_resp  = 1'b0;
        dfp_read  = 1'b0;
        dfp_write = 1'b0;

        case (state_q)
            idle: begin
                if (cpu_req) begin
                    state_d = compare_tag;
                end
            end
            compare_tag: begin
                if (!cpu_req) begin
                    state_d = idle;  // Request withdrawn
                end else if (hit) begin
                    cpu_resp = 1'b1;
                    sram_op  = cpu_write ? cache_pkg::HIT_WRITE_DIRTY
                                         : cache_pkg::HIT_READ_CLEAN;
                    state_d  = idle;
                end else if (dirty_miss) begin
                    state_d = write_back;
                end else if (clean_miss) begin
                    state_d = allocate;
                end
            end
            write_back: begin
                dfp_write = 1'b1;
                if (dfp_resp) begin
                    state_d = allocate;
                end
            end
            allocate: begin
                dfp_read = 1'b1;
                if (dfp_resp) begin
                    sram_op = cache_pkg::MISS_REPLACE;
                    state_d = idle;  // Retry through compare
                end
            end
            default: begin
                state_d = idle;
            end
        endcase
    end

    a_dfp_excl: assert property (@(posedge clk) disable iff (rst)
        !(dfp_read && dfp_write))
        else $error("dfp_read and dfp_write high together");

    a_resp_on_hit: assert property (@(posedge clk) disable iff (rst)
        cpu_resp |-> (state_q == compare_tag) && hit && $past(cpu_req))
        else $error("cpu_resp outside a compare hit");

endmodule

// ==== hdl/cache_data_array.sv ====
`timescale 1ns/1ps

module cache_data_array #(
    parameter int NUM_SETS = 8
) (
    input  logic                clk,
    input  cache_pkg::addr_t    cpu_addr,
    input  cache_pkg::word_t    cpu_wdata,
    input  cache_pkg::sram_op_t sram_op,
    input  cache_pkg::line_t    dfp_rdata,
    output cache_pkg::word_t    cpu_rdata,
    output cache_pkg::line_t    dfp_wdata
);

    localparam int IDX_W = $clog2(NUM_SETS);

    cache_pkg::line_t line_mem [NUM_SETS];

    logic [IDX_W-1:0]              idx;
    logic [cache_pkg::OFFSET_W-1:0] word_sel;
    cache_pkg::line_t              cur_line;

    assign idx      = cpu_addr[cache_pkg::OFFSET_W +: IDX_W];
    assign word_sel = cpu_addr[cache_pkg::OFFSET_W-1:0];
    assign cur_line = line_mem[idx];

    assign cpu_rdata = cur_line[word_sel*cache_pkg::WORD_W +: cache_pkg::WORD_W];
    assign dfp_wdata = cur_line;  // Always the indexed line, used on write-back

    always_ff @(posedge clk) begin
        case (sram_op)
            cache_pkg::HIT_WRITE_DIRTY: begin
                line_mem[idx][word_sel*cache_pkg::WORD_W +: cache_pkg::WORD_W] <= cpu_wdata;
            end
            cache_pkg::MISS_REPLACE: begin
                line_mem[idx] <= dfp_rdata;
            end
            default: ;
        endcase
    end

    // Once the controller is out of reset the command stays defined
    a_op_known: assert property (@(posedge clk)
        !$isunknown($past(sram_op)) |-> !$isunknown(sram_op))
        else $error("sram_op became unknown");

endmodule

// ==== hdl/cache_pkg.sv ====
package cache_pkg;

    // Word address geometry
    localparam int ADDR_W         = 16;
    localparam int WORD_W         = 32;
    localparam int WORDS_PER_LINE = 4;
    localparam int OFFSET_W       = $clog2(WORDS_PER_LINE);
    localparam int LINE_W         = WORDS_PER_LINE * WORD_W;

    typedef logic [ADDR_W-1:0] addr_t;  // Tag | index | word offset
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [LINE_W-1:0] line_t;  // Word 0 in the low bits

    // Word address without the word offset
    typedef logic [ADDR_W-OFFSET_W-1:0] line_addr_t;

    // Command from the controller to both arrays
    typedef logic [1:0] sram_op_t;

    localparam sram_op_t SRAM_NOP        = 2'd0;
    localparam sram_op_t HIT_READ_CLEAN  = 2'd1;  // Read one word
    localparam sram_op_t HIT_WRITE_DIRTY = 2'd2;  // Merge one word, mark dirty
    localparam sram_op_t MISS_REPLACE    = 2'd3;  // Fill line, set valid and tag

endpackage

// ==== hdl/cache_tag_array.sv ====
`timescale 1ns/1ps

module cache_tag_array #(
    parameter int NUM_SETS = 8
) (
    input  logic                clk,
    input  logic                rst,
    input  cache_pkg::addr_t    cpu_addr,
    input  cache_pkg::sram_op_t sram_op,
    input  logic                dfp_write,
    output logic                hit,
    output logic                dirty_miss,
    output logic                clean_miss,
    output cache_pkg::addr_t    dfp_addr
);

    localparam int IDX_W = $clog2(NUM_SETS);
    localparam int TAG_W = cache_pkg::ADDR_W - cache_pkg::OFFSET_W - IDX_W;

    logic [NUM_SETS-1:0] valid_q;
    logic [NUM_SETS-1:0] dirty_q;
    logic [TAG_W-1:0]    tag_q [NUM_SETS];

    logic [IDX_W-1:0] idx;
    logic [TAG_W-1:0] req_tag;
    logic             tag_match;
    logic             victim_dirty;

    assign idx     = cpu_addr[cache_pkg::OFFSET_W +: IDX_W];
    assign req_tag = cpu_addr[cache_pkg::ADDR_W-1 -: TAG_W];

    assign tag_match    = valid_q[idx] && (tag_q[idx] == req_tag);
    assign victim_dirty = valid_q[idx] && dirty_q[idx];

    assign hit        = tag_match;
    assign dirty_miss = !tag_match && victim_dirty;
    assign clean_miss = !tag_match && !victim_dirty;

    // Write-back goes to the victim's own line
    assign dfp_addr = dfp_write ? {tag_q[idx], idx, {cache_pkg::OFFSET_W{1'b0}}}
                                : {req_tag, idx, {cache_pkg::OFFSET_W{1'b0}}};

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            case (sram_op)
                cache_pkg::HIT_WRITE_DIRTY: dirty_q[idx] <= 1'b1;
                cache_pkg::MISS_REPLACE: begin
                    valid_q[idx] <= 1'b1;
                    dirty_q[idx] <= 1'b0;  // Fresh from memory
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (sram_op == cache_pkg::MISS_REPLACE) begin
            tag_q[idx] <= req_tag;
        end
    end

    a_one_class: assert property (@(posedge clk) disable iff (rst)
        $onehot0({hit, dirty_miss, clean_miss}))
        else $error("more than one hit/miss class active");

    // Request is still held after a fill, so the retry must hit
    a_fill_hits: assert property (@(posedge clk) disable iff (rst)
        sram_op == cache_pkg::MISS_REPLACE |=> hit)
        else $error("no hit on the cycle after a line fill");

endmodule

// ==== hdl/cache_top.sv ====
`timescale 1ns/1ps

module cache_top #(
    parameter int NUM_SETS = 8
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             cpu_read,
    input  logic             cpu_write,
    input  cache_pkg::addr_t cpu_addr,
    input  cache_pkg::word_t cpu_wdata,
    input  cache_pkg::line_t dfp_rdata,
    input  logic             dfp_resp,
    output logic             cpu_resp,
    output cache_pkg::word_t cpu_rdata,
    output logic             dfp_read,
    output logic             dfp_write,
    output cache_pkg::addr_t dfp_addr,
    output cache_pkg::line_t dfp_wdata
);

    cache_pkg::sram_op_t sram_op;
    logic                hit;
    logic                dirty_miss;
    logic                clean_miss;

    cache_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .cpu_read   (cpu_read),
        .cpu_write  (cpu_write),
        .hit        (hit),
        .dirty_miss (dirty_miss),
        .clean_miss (clean_miss),
        .dfp_resp   (dfp_resp),
        .sram_op    (sram_op),
        .cpu_resp   (cpu_resp),
        .dfp_read   (dfp_read),
        .dfp_write  (dfp_write)
    );

    cache_tag_array #(.NUM_SETS(NUM_SETS)) u_tags (
        .clk        (clk),
        .rst        (rst),
        .cpu_addr   (cpu_addr),
        .sram_op    (sram_op),
        .dfp_write  (dfp_write),  // Selects victim address
        .hit        (hit),
        .dirty_miss (dirty_miss),
        .clean_miss (clean_miss),
        .dfp_addr   (dfp_addr)
    );

    cache_data_array #(.NUM_SETS(NUM_SETS)) u_data (
        .clk       (clk),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .sram_op   (sram_op),
        .dfp_rdata (dfp_rdata),
        .cpu_rdata (cpu_rdata),
        .dfp_wdata (dfp_wdata)
    );

endmodule

// ==== run.sh ====
#!/bin/sh
# Build the cache testbench with Verilator, run it, and look for the pass line
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_cache \
    -f sim.f -o tb_cache > build.log 2>&1 \
    && ./obj_dir/tb_cache > sim.log 2>&1 \
    && grep -qx "all tests passed" sim.log \
    && echo "PASS" \
    || { echo "FAIL (see build.log and sim.log)"; exit 1; }

// ==== sim.f ====
hdl/cache_pkg.sv
hdl/cache_ctrl.sv
hdl/cache_tag_array.sv
hdl/cache_data_array.sv
hdl/cache_top.sv
test/cache_checker.sv
test/tb_cache.sv

// ==== test/cache_checker.sv ====
`timescale 1ns/1ps

module cache_checker (
    input  logic             clk,
    input  logic             rst,
    input  logic             cpu_read,
    input  logic             cpu_write,
    input  cache_pkg::addr_t cpu_addr,
    input  cache_pkg::word_t cpu_wdata,
    input  logic             cpu_resp,
    input  cache_pkg::word_t cpu_rdata,
    input  logic             dfp_read,
    input  logic             dfp_write,
    input  cache_pkg::addr_t dfp_addr,
    input  cache_pkg::line_t dfp_wdata,
    input  logic             dfp_resp,
    output int               value_errors,
    output int               protocol_errors,
    output int               reads_checked,
    output int               lines_checked
);

    localparam int MEM_WORDS = 2 ** cache_pkg::ADDR_W;

    cache_pkg::word_t ref_mem [MEM_WORDS];  // Word-level reference memory

    logic                  req_seen;
    logic                  pending;     // Request sampled, no response yet
    logic                  wb_open;
    logic                  mem_seen;
    logic                  same_line;
    logic                  last_valid;
    cache_pkg::line_addr_t last_line;
    cache_pkg::addr_t      miss_addr;
    int                    cycle;
    int                    start_cycle;

    function automatic cache_pkg::word_t pattern_word(input cache_pkg::addr_t a);
        return {a ^ 16'h9e37, a};
    endfunction

    function automatic cache_pkg::line_t ref_line(input cache_pkg::addr_t base);
        cache_pkg::line_t l;
        for (int w = 0; w < cache_pkg::WORDS_PER_LINE; w++) begin
            l[w*cache_pkg::WORD_W +: cache_pkg::WORD_W] = ref_mem[base + cache_pkg::addr_t'(w)];
        end
        return l;
    endfunction

    task automatic error_value(input string test, input logic [127:0] expected,
                               input logic [127:0] actual);
        $display("Error: %s expected %0h actual %0h at %0t", test, expected, actual, $time);
        value_errors++;
    endtask

    task automatic error_note(input string what);
        $display("Protocol failure: %s at %0t", what, $time);
        protocol_errors++;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            for (int a = 0; a < MEM_WORDS; a++) begin
                ref_mem[a] = pattern_word(cache_pkg::addr_t'(a));
            end
            value_errors    = 0;
            protocol_errors = 0;
            reads_checked   = 0;
            lines_checked   = 0;
            req_seen        = 1'b0;
            pending         = 1'b0;
            wb_open         = 1'b0;
            mem_seen        = 1'b0;
            same_line       = 1'b0;
            last_valid      = 1'b0;
            last_line       = '0;
            cycle           = 0;
            start_cycle     = 0;
        end else begin
            if (!req_seen && (cpu_resp || dfp_read || dfp_write))
                error_note("DUT output active before the first request");
            if (cpu_read || cpu_write)
                req_seen = 1'b1;

            // Memory port ordering and addresses
            if (dfp_read && dfp_write)
                error_note("dfp_read and dfp_write high together");
            if ((dfp_read || dfp_write) && dfp_addr[cache_pkg::OFFSET_W-1:0] != '0)
                error_note("memory address is not line aligned");
            if (dfp_read && wb_open)
                error_note("line read began before the write-back completed");
            if (dfp_read) begin
                miss_addr = {cpu_addr[cache_pkg::ADDR_W-1:cache_pkg::OFFSET_W],
                             {cache_pkg::OFFSET_W{1'b0}}};
                if (dfp_addr !== miss_addr)
                    error_value("miss_read_addr", miss_addr, dfp_addr);
            end
            if (dfp_write) begin
                wb_open = !dfp_resp;
                if (dfp_resp) begin
                    lines_checked++;
                    if (dfp_wdata !== ref_line(dfp_addr))
                        error_value("write_back_line", ref_line(dfp_addr), dfp_wdata);
                end
            end

            if (pending) begin
                if (dfp_read || dfp_write)
                    mem_seen = 1'b1;
                if (cpu_resp) begin
                    if (cpu_read) begin
                        reads_checked++;
                        if (cpu_rdata !== ref_mem[cpu_addr])
                            error_value("read_data", ref_mem[cpu_addr], cpu_rdata);
                    end
                    if (cpu_write)
                        ref_mem[cpu_addr] = cpu_wdata;
                    if (same_line && cycle - start_cycle != 1)
                        error_value("repeat_latency", 1, cycle - start_cycle);
                    if (same_line && mem_seen)
                        error_note("memory access on a repeated line");
                    last_line  = cpu_addr[cache_pkg::ADDR_W-1:cache_pkg::OFFSET_W];
                    last_valid = 1'b1;
                    pending    = 1'b0;
                end
            end else if (cpu_resp) begin
                error_note("cpu_resp without a pending request");
            end else if (cpu_read || cpu_write) begin
                pending     = 1'b1;
                start_cycle = cycle;
                mem_seen    = 1'b0;
                same_line   = last_valid &&
                    (cpu_addr[cache_pkg::ADDR_W-1:cache_pkg::OFFSET_W] == last_line);
            end
            cycle++;
        end
    end

endmodule

// ==== test/tb_cache.sv ====
`timescale 1ns/1ps

module tb_cache;

    localparam int NUM_SETS    = 8;
    localparam int N_TRANS     = 400;
    localparam int MAX_DELAY   = 8;
    localparam int CLK_PERIOD  = 100;
    localparam int MEM_WORDS   = 2 ** cache_pkg::ADDR_W;
    localparam int WATCHDOG_NS = N_TRANS * (2 * MAX_DELAY + 8) * CLK_PERIOD + 20 * CLK_PERIOD;

    logic             clk;
    logic             rst;
    logic             cpu_read;
    logic             cpu_write;
    cache_pkg::addr_t cpu_addr;
    cache_pkg::word_t cpu_wdata;
    logic             cpu_resp;
    cache_pkg::word_t cpu_rdata;
    logic             dfp_read;
    logic             dfp_write;
    cache_pkg::addr_t dfp_addr;
    cache_pkg::line_t dfp_wdata;
    cache_pkg::line_t dfp_rdata;
    logic             dfp_resp;

    int value_errors;
    int protocol_errors;
    int reads_checked;
    int lines_checked;
    int seed;

    cache_pkg::word_t mem [MEM_WORDS];  // Backing memory

    function automatic cache_pkg::word_t pattern_word(input cache_pkg::addr_t a);
        return {a ^ 16'h9e37, a};
    endfunction

    function automatic cache_pkg::line_t fetch_line(input cache_pkg::addr_t base);
        cache_pkg::line_t l;
        for (int w = 0; w < cache_pkg::WORDS_PER_LINE; w++) begin
            l[w*cache_pkg::WORD_W +: cache_pkg::WORD_W] = mem[base + cache_pkg::addr_t'(w)];
        end
        return l;
    endfunction

    task automatic store_line(input cache_pkg::addr_t base, input cache_pkg::line_t l);
        for (int w = 0; w < cache_pkg::WORDS_PER_LINE; w++) begin
            mem[base + cache_pkg::addr_t'(w)] = l[w*cache_pkg::WORD_W +: cache_pkg::WORD_W];
        end
    endtask

    // Starts 1 ns after an edge and returns 1 ns after the response edge
    task automatic run_request(input cache_pkg::addr_t addr, input logic wr,
                               input cache_pkg::word_t data);
        cpu_addr  = addr;
        cpu_wdata = data;
        cpu_read  = !wr;
        cpu_write = wr;
        @(posedge clk);
        while (!cpu_resp) @(posedge clk);
        #1;
        cpu_read  = 1'b0;
        cpu_write = 1'b0;
    endtask

    task automatic print_summary();
        $display("Summary: %0d reads, %0d lines, %0d value errors, %0d protocol errors",
                 reads_checked, lines_checked, value_errors, protocol_errors);
    endtask

    cache_top #(.NUM_SETS(NUM_SETS)) UUT (
        .clk       (clk),
        .rst       (rst),
        .cpu_read  (cpu_read),
        .cpu_write (cpu_write),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .dfp_rdata (dfp_rdata),
        .dfp_resp  (dfp_resp),
        .cpu_resp  (cpu_resp),
        .cpu_rdata (cpu_rdata),
        .dfp_read  (dfp_read),
        .dfp_write (dfp_write),
        .dfp_addr  (dfp_addr),
        .dfp_wdata (dfp_wdata)
    );

    cache_checker u_checker (
        .clk             (clk),
        .rst             (rst),
        .cpu_read        (cpu_read),
        .cpu_write       (cpu_write),
        .cpu_addr        (cpu_addr),
        .cpu_wdata       (cpu_wdata),
        .cpu_resp        (cpu_resp),
        .cpu_rdata       (cpu_rdata),
        .dfp_read        (dfp_read),
        .dfp_write       (dfp_write),
        .dfp_addr        (dfp_addr),
        .dfp_wdata       (dfp_wdata),
        .dfp_resp        (dfp_resp),
        .value_errors    (value_errors),
        .protocol_errors (protocol_errors),
        .reads_checked   (reads_checked),
        .lines_checked   (lines_checked)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin : memory_model
        cache_pkg::addr_t req_addr;
        cache_pkg::line_t req_line;
        logic             req_write;
        int               delay;
        dfp_resp  = 1'b0;
        dfp_rdata = '0;
        for (int a = 0; a < MEM_WORDS; a++) begin
            mem[a] = pattern_word(cache_pkg::addr_t'(a));
        end
        forever begin
            @(posedge clk);
            if (!rst && (dfp_read || dfp_write)) begin
                req_addr  = dfp_addr;  // Levels and data are held until dfp_resp
                req_write = dfp_write;
                req_line  = dfp_wdata;
                delay     = 1 + int'($unsigned($random(seed)) % MAX_DELAY);
                repeat (delay - 1) @(posedge clk);
                #1;
                if (req_write)
                    store_line(req_addr, req_line);
                else
                    dfp_rdata = fetch_line(req_addr);
                dfp_resp = 1'b1;
                @(posedge clk);
                #1;
                dfp_resp = 1'b0;
            end
        end
    end

    initial begin : stimulus
        cache_pkg::addr_t addr;
        int               line;
        int               last_line;
        int               gap;
        logic             wr;
        seed      = 32'hb8de0446;
        rst       = 1'b1;
        cpu_read  = 1'b0;
        cpu_write = 1'b0;
        cpu_addr  = '0;
        cpu_wdata = '0;
        last_line = 0;
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;
        repeat (3) @(posedge clk);  // Quiet cycles before the first request
        #1;
        for (int t = 0; t < N_TRANS; t++) begin
            line = int'($unsigned($random(seed)) % (4 * NUM_SETS));
            if ($unsigned($random(seed)) % 4 == 0)
                line = last_line;  // Favor back-to-back hits on one line
            addr = cache_pkg::addr_t'(line * cache_pkg::WORDS_PER_LINE +
                   int'($unsigned($random(seed)) % cache_pkg::WORDS_PER_LINE));
            wr   = ($unsigned($random(seed)) % 2) == 1;
            run_request(addr, wr, $random(seed));
            last_line = line;
            gap = int'($unsigned($random(seed)) % 2);
            if (gap > 0) begin
                repeat (gap) @(posedge clk);
                #1;
            end
        end
        repeat (4) @(posedge clk);
        print_summary();
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        print_summary();
        $display("tests failed");
        $finish;
    end

endmodule
